// ==== filelist.f ====
verilog/mac_pkg.sv
verilog/operand_packer.sv
verilog/packed_mult_u24_s18.sv
verilog/packed_mac_dsp.sv
verilog/mac_sequencer.sv
verilog/packed_mac_engine.sv
test/packed_mac_properties.sv
test/tb_packed_mac_engine.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the packed MAC engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module tb_packed_mac_engine -o sim \
  && ./obj_dir/sim 2>&1 | tee "$LOG" \
  || echo "Build or simulation returned an error"

grep -q "^ALL CHECKS PASSED$" "$LOG" 2>/dev/null \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed, see $LOG"; exit 1; }

// ==== test/packed_mac_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module packed_mac_properties (
  input logic                 clk,
  input logic                 reset,
  input logic                 in_ready,
  input logic                 out_valid,
  input logic                 out_ready,
  input mac_pkg::mac_result_s out_result
);

  // Count of failed properties
  int failures = 0;

  ////////////////////////////////////////
  // Reset
  ////////////////////////////////////////

  idle_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
    else begin
      failures = failures + 1;
      $error("out_valid high in the cycle after reset");
    end

  ////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////

  // Stalled result keeps valid and data
  result_held: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_result))
    else begin
      failures = failures + 1;
      $error("out_result changed while stalled");
    end

  input_closed: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> !in_ready)
    else begin
      failures = failures + 1;
      $error("in_ready high while a result is pending");
    end

endmodule

bind packed_mac_engine packed_mac_properties props_i (
  .clk        (clk),
  .reset      (reset),
  .in_ready   (in_ready),
  .out_valid  (out_valid),
  .out_ready  (out_ready),
  .out_result (out_result)
);

`default_nettype wire

// ==== test/tb_packed_mac_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_packed_mac_engine;

  import mac_pkg::*;

  localparam int LATENCY      = 5;
  localparam int WRAP_LEN     = 320;
  localparam int KIND_RANDOM  = 0;
  localparam int KIND_EXTREME = 1;
  localparam int KIND_NEG_MAX = 2;
  localparam int KIND_POS_MAX = 3;

  logic        clk = 1'b0;
  logic        reset;
  logic        in_valid;
  mac_beat_s   in_beat;
  logic        out_ready;
  logic        in_ready;
  logic        out_valid;
  mac_result_s out_result;

  // Job stimulus and expected results built before reset
  mac_beat_s   beats[$];
  int          job_len[$];
  string       job_name[$];
  mac_result_s expected[$];
  int          n_jobs = 0;
  int          total_beats = 0;
  int          first_bp_job = 0;

  logic [31:0] gen_seed = 32'd96;
  logic [31:0] ready_seed = 32'd96;
  logic        gaps_on = 1'b0;
  int          cycle = 0;
  int          cycle_limit = 0;
  int          result_count = 0;
  int          last_accept_cycle = 0;
  logic        out_valid_seen = 1'b0;
  logic        close_due = 1'b0;
  logic        open_due = 1'b0;

  packed_mac_engine dut_i (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_beat    (in_beat),
    .out_ready  (out_ready),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_result (out_result)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int draw(input int lo, input int hi);
    gen_seed = lcg_step(gen_seed);
    return lo + int'({8'h00, gen_seed[31:8]} % (hi - lo + 1));
  endfunction

  // 24-bit lanes in 8x8 mode, 16-bit lanes in 4x4 mode
  function automatic lane_t wrap_lane(input int sum, input mac_mode_e mode);
    if (mode == MODE_8X8) begin
      return sum[23:0];
    end
    return {{8{sum[15]}}, sum[15:0]};
  endfunction

  function automatic mac_result_s expected_result(input int start, input int count);
    mac_result_s r;
    mac_mode_e   mode;
    int          s0;
    int          s1;
    int          s2;
    int          s3;
    int          px0;
    int          px1;
    int          w0;
    int          w1;
    mode = beats[start].mode;
    s0 = 0;
    s1 = 0;
    s2 = 0;
    s3 = 0;
    for (int i = start; i < start + count; i++) begin
      if (mode == MODE_8X8) begin
        px0 = int'(beats[i].pix0);
        px1 = int'(beats[i].pix1);
        w0  = int'($signed(beats[i].wgt0));
        s0  = s0 + px0 * w0;
        s1  = s1 + px1 * w0;
      end else begin
        // Unsigned pixel nibbles, signed weight nibbles
        px0 = int'(beats[i].pix0[3:0]);
        px1 = int'(beats[i].pix1[3:0]);
        w0  = int'($signed(beats[i].wgt0[3:0]));
        w1  = int'($signed(beats[i].wgt1[3:0]));
        s0  = s0 + px0 * w0;
        s1  = s1 + px0 * w1;
        s2  = s2 + px1 * w0;
        s3  = s3 + px1 * w1;
      end
    end
    r       = '0;
    r.mode  = mode;
    r.lane0 = wrap_lane(s0, mode);
    r.lane1 = wrap_lane(s1, mode);
    if (mode == MODE_4X4) begin
      r.lane2 = wrap_lane(s2, mode);
      r.lane3 = wrap_lane(s3, mode);
    end
    return r;
  endfunction

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_result(input string name, input mac_result_s exp,
                              input mac_result_s act);
    if (act !== exp) begin
      fail_stop($sformatf("ERROR %s expected %0d %0d %0d %0d actual %0d %0d %0d %0d",
                          name, $signed(exp.lane0), $signed(exp.lane1),
                          $signed(exp.lane2), $signed(exp.lane3),
                          $signed(act.lane0), $signed(act.lane1),
                          $signed(act.lane2), $signed(act.lane3)));
    end
  endtask

  task automatic check_mode(input string name, input mac_mode_e exp, input mac_mode_e act);
    if (act !== exp) begin
      fail_stop($sformatf("ERROR %s expected mode %s actual mode %s",
                          name, exp.name(), act.name()));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      fail_stop($sformatf("ERROR %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_stop($sformatf("ERROR %s expected %0b actual %0b", name, exp, act));
    end
  endtask

  ////////////////////////////////////////
  // Job construction
  ////////////////////////////////////////

  task automatic add_job(input string name, input mac_mode_e mode, input int len,
                         input int kind);
    mac_beat_s b;
    int        start;
    start = beats.size();
    for (int i = 0; i < len; i++) begin
      b.mode = mode;
      b.pix0 = pixel_t'(draw(0, 255));
      b.pix1 = pixel_t'(draw(0, 255));
      b.wgt0 = weight_t'(draw(-128, 127));
      b.wgt1 = weight_t'(draw(-128, 127));
      if (kind == KIND_EXTREME) begin
        // Upper nibbles stay random and must be ignored
        b.pix0[3:0] = 4'hF;
        b.pix1[3:0] = 4'hF;
        b.wgt0[3:0] = (draw(0, 1) == 1) ? 4'h8 : 4'h7;
        b.wgt1[3:0] = (draw(0, 1) == 1) ? 4'h8 : 4'h7;
      end else if (kind == KIND_NEG_MAX || kind == KIND_POS_MAX) begin
        b.pix0 = 8'hFF;
        b.pix1 = 8'hFF;
        if (mode == MODE_8X8) begin
          b.wgt0 = (kind == KIND_NEG_MAX) ? -8'sd128 : 8'sd127;
        end else begin
          b.wgt0 = (kind == KIND_NEG_MAX) ? 8'h08 : 8'h07;
          b.wgt1 = (kind == KIND_NEG_MAX) ? 8'h08 : 8'h07;
        end
      end
      b.last = (i == len - 1);
      beats.push_back(b);
    end
    job_len.push_back(len);
    job_name.push_back(name);
    expected.push_back(expected_result(start, len));
  endtask

  task automatic build_jobs();
    for (int j = 0; j < 6; j++) begin
      add_job("mode0_accuracy", MODE_8X8, draw(1, 12), KIND_RANDOM);
    end
    for (int j = 0; j < 6; j++) begin
      add_job("mode1_extreme", MODE_4X4, draw(1, 12), KIND_EXTREME);
    end
    // Long enough to pass the lane range in both directions
    add_job("wrap_around", MODE_8X8, WRAP_LEN, KIND_NEG_MAX);
    add_job("wrap_around", MODE_8X8, WRAP_LEN, KIND_POS_MAX);
    add_job("wrap_around", MODE_4X4, WRAP_LEN, KIND_NEG_MAX);
    add_job("wrap_around", MODE_4X4, WRAP_LEN, KIND_POS_MAX);
    for (int j = 0; j < 8; j++) begin
      add_job("job_restart", (j % 2 == 1) ? MODE_4X4 : MODE_8X8, draw(1, 12), KIND_RANDOM);
    end
    first_bp_job = job_len.size();
    for (int j = 0; j < 12; j++) begin
      add_job("back_pressure", (draw(0, 1) == 1) ? MODE_4X4 : MODE_8X8, draw(1, 12),
              KIND_RANDOM);
    end
    n_jobs      = job_len.size();
    total_beats = beats.size();
  endtask

  task automatic send_beat(input mac_beat_s b);
    in_valid = 1'b1;
    in_beat  = b;
    @(negedge clk);
    while (!in_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin : stimulus
    int idx;
    int gap;
    reset    = 1'b1;
    in_valid = 1'b0;
    in_beat  = '0;
    build_jobs();
    cycle_limit = 40 * total_beats + 200;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    idx   = 0;
    for (int j = 0; j < n_jobs; j++) begin
      gaps_on = (j >= first_bp_job);
      for (int k = 0; k < job_len[j]; k++) begin
        if (gaps_on) begin
          gap = draw(0, 3);
          repeat (gap) begin
            @(posedge clk);
            #1;
          end
        end
        send_beat(beats[idx]);
        idx = idx + 1;
      end
    end
    // Input opens again once the last result is taken
    wait (in_ready);
    // Window for a duplicate result to show up
    repeat (20) @(posedge clk);
    if (result_count != n_jobs) begin
      fail_stop($sformatf("ERROR result_count expected %0d actual %0d",
                          n_jobs, result_count));
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

  // Output ready held high until the back-pressure jobs
  initial begin : ready_driver
    out_ready = 1'b0;
    @(negedge reset);
    forever begin
      if (gaps_on) begin
        ready_seed = lcg_step(ready_seed);
        out_ready  = (ready_seed[17:16] != 2'b00);
      end else begin
        out_ready = 1'b1;
      end
      @(posedge clk);
      #1;
    end
  end

  ////////////////////////////////////////
  // Monitor and timeout
  ////////////////////////////////////////

  always @(negedge clk) begin : compare_results
    mac_result_s exp_r;
    string       name;
    if (dut_i.props_i.failures != 0) begin
      fail_stop("A bound handshake assertion failed");
    end
    if (!reset) begin
      // Input closes after a last beat and reopens after a take
      if (close_due) begin
        check_flag("in_ready_close", 1'b0, in_ready);
      end
      if (open_due) begin
        check_flag("in_ready_open", 1'b1, in_ready);
      end
      close_due = in_valid && in_ready && in_beat.last;
      open_due  = out_valid && out_ready;
      if (in_valid && in_ready && in_beat.last) begin
        last_accept_cycle = cycle;
      end
      if (out_valid && !out_valid_seen) begin
        check_count("latency", LATENCY, cycle - last_accept_cycle);
      end
      out_valid_seen = out_valid;
      if (out_valid && out_ready) begin
        if (expected.size() == 0) begin
          fail_stop("A result was delivered with no job outstanding");
        end
        exp_r = expected.pop_front();
        name  = job_name.pop_front();
        check_mode(name, exp_r.mode, out_result.mode);
        check_result(name, exp_r, out_result);
        result_count = result_count + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle_limit > 0 && cycle > cycle_limit) begin
      fail_stop($sformatf("Timeout after %0d cycles with %0d of %0d results received",
                          cycle, result_count, n_jobs));
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mac_pkg.sv ====
`default_nettype none

package mac_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Guard bits above the raw product width of each lane
  localparam int ACC_HEADROOM = 8;

  // 8x8 lanes hold 16-bit products, 4x4 lanes hold 8-bit products
  localparam int LANE8_W = 16 + ACC_HEADROOM;
  localparam int LANE4_W = 8 + ACC_HEADROOM;

  // Four 4x4 lanes side by side
  localparam int ACC_W = 4 * LANE4_W;

  // DSP multiplier port widths
  localparam int DSP_A_W = 24;
  localparam int DSP_B_W = 18;
  localparam int DSP_P_W = DSP_A_W + DSP_B_W;

  // Output lanes are as wide as the widest accumulator lane
  localparam int LANE_W = LANE8_W;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [7:0]          pixel_t;
  typedef logic signed [7:0]   weight_t;
  typedef logic [DSP_A_W-1:0]  dsp_a_t;
  typedef logic [DSP_B_W-1:0]  dsp_b_t;
  typedef logic [DSP_P_W-1:0]  dsp_p_t;
  typedef logic [ACC_W-1:0]    acc_t;
  typedef logic signed [LANE_W-1:0] lane_t;

  typedef enum logic {
    MODE_8X8 = 1'b0,
    MODE_4X4 = 1'b1
  } mac_mode_e;

  // One input beat; in 4x4 mode only the low nibbles count
  typedef struct packed {
    mac_mode_e mode;
    pixel_t    pix0;
    pixel_t    pix1;
    weight_t   wgt0;
    weight_t   wgt1;
    logic      last;
  } mac_beat_s;

  typedef struct packed {
    mac_mode_e mode;
    lane_t     lane0;
    lane_t     lane1;
    lane_t     lane2;
    lane_t     lane3;
  } mac_result_s;

endpackage

`default_nettype wire

// ==== verilog/mac_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_sequencer (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_valid,
  input  logic                 in_last,
  input  mac_pkg::mac_mode_e   in_mode,
  input  logic                 out_ready,
  input  mac_pkg::acc_t        acc,
  output logic                 in_ready,
  output logic                 beat_accept,
  output logic                 acc_en,
  output logic                 acc_clear,
  output mac_pkg::mac_mode_e   acc_mode,
  output logic                 out_valid,
  output mac_pkg::mac_result_s out_result
);

  import mac_pkg::*;

  typedef enum logic [1:0] {
    COLLECT,
    DRAIN,
    HOLD
  } state_e;

  // One beat's control record as it moves with its data
  typedef struct packed {
    logic      valid;
    logic      first;
    mac_mode_e mode;
  } track_s;

  state_e      state_q;
  track_s      track_q [3];
  logic        first_pending;
  logic        drain_done;
  mac_mode_e   job_mode;
  mac_result_s result_d;
  mac_result_s result_q;

  // Narrow lane to a full output lane
  function automatic lane_t widen4(input logic [LANE4_W-1:0] v);
    return {{(LANE_W - LANE4_W){v[LANE4_W-1]}}, v};
  endfunction

  ////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////

  assign in_ready    = (state_q == COLLECT);
  assign beat_accept = in_valid && in_ready;
  assign out_valid   = (state_q == HOLD);
  assign out_result  = result_q;

  ////////////////////////////////////////
  // Tracking pipeline
  ////////////////////////////////////////

  // Stage 0 lines up with the packer, stage 2 with the product
  always_ff @(posedge clk) begin
    if (reset) begin
      track_q[0] <= '0;
      track_q[1] <= '0;
      track_q[2] <= '0;
    end else begin
      track_q[0].valid <= beat_accept;
      track_q[0].first <= beat_accept && first_pending;
      track_q[0].mode  <= in_mode;
      track_q[1]       <= track_q[0];
      track_q[2]       <= track_q[1];
    end
  end

  assign acc_en    = track_q[2].valid;
  assign acc_clear = track_q[2].first;
  assign acc_mode  = track_q[2].mode;

  // Last beat has landed once the pipeline runs empty
  assign drain_done = (state_q == DRAIN) &&
                      !(track_q[0].valid || track_q[1].valid || track_q[2].valid);

  ////////////////////////////////////////
  // Job FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q       <= COLLECT;
      first_pending <= 1'b1;
    end else begin
      case (state_q)
        COLLECT: begin
          if (beat_accept && in_last) begin
            state_q <= DRAIN;
          end
        end
        DRAIN: begin
          if (drain_done) begin
            state_q <= HOLD;
          end
        end
        HOLD: begin
          if (out_ready) begin
            state_q <= COLLECT;
          end
        end
        default: begin
          state_q <= COLLECT;
        end
      endcase
      if (beat_accept) begin
        first_pending <= 1'b0;
      end else if (out_valid && out_ready) begin
        first_pending <= 1'b1;
      end
    end
  end

  // Unpack by mode; 8x8 uses only two lanes
  always_comb begin
    result_d      = '0;
    result_d.mode = job_mode;
    if (job_mode == MODE_8X8) begin
      result_d.lane0 = acc[0 +: LANE8_W];
      result_d.lane1 = acc[LANE8_W +: LANE8_W];
    end else begin
      result_d.lane0 = widen4(acc[0 +: LANE4_W]);
      result_d.lane1 = widen4(acc[LANE4_W +: LANE4_W]);
      result_d.lane2 = widen4(acc[2*LANE4_W +: LANE4_W]);
      result_d.lane3 = widen4(acc[3*LANE4_W +: LANE4_W]);
    end
  end

  always_ff @(posedge clk) begin
    if (beat_accept) begin
      job_mode <= in_mode;
    end
    if (drain_done) begin
      result_q <= result_d;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/operand_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_packer (
  input  logic               clk,
  input  logic               reset,
  input  logic               beat_accept,
  input  mac_pkg::mac_beat_s beat,
  output mac_pkg::dsp_a_t    dsp_a,
  output mac_pkg::dsp_b_t    dsp_b
);

  import mac_pkg::*;

  dsp_a_t a_next;
  dsp_b_t b_next;

  ////////////////////////////////////////
  // Operand layout
  ////////////////////////////////////////

  // Pixels always sit at bits 0 and 16 of A.
  // B carries one weight in 8x8 mode and two nibble weights in 4x4 mode,
  // so one product holds every lane at a fixed field offset.
  always_comb begin
    a_next = '0;
    b_next = '0;
    if (beat.mode == MODE_8X8) begin
      // Two 16-bit fields, pix0*w at 0 and pix1*w at 16
      a_next[7:0]   = beat.pix0;
      a_next[23:16] = beat.pix1;
      b_next        = {{(DSP_B_W - 8){beat.wgt0[7]}}, beat.wgt0};
    end else begin
      a_next[3:0]   = beat.pix0[3:0];
      a_next[19:16] = beat.pix1[3:0];
      // wgt1 shifted up one 8-bit field
      // fields at 0, 8, 16, 24 are p0*w0, p0*w1, p1*w0, p1*w1
      b_next = {{(DSP_B_W - 4){beat.wgt0[3]}}, beat.wgt0[3:0]}
             + {{(DSP_B_W - 12){beat.wgt1[3]}}, beat.wgt1[3:0], 8'h00};
    end
  end

  ////////////////////////////////////////
  // Operand registers
  ////////////////////////////////////////

  // Loaded once per accepted beat, held otherwise
  always_ff @(posedge clk) begin
    if (reset) begin
      dsp_a <= '0;
      dsp_b <= '0;
    end else if (beat_accept) begin
      dsp_a <= a_next;
      dsp_b <= b_next;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/packed_mac_dsp.sv ====
`timescale 1ns/1ps
`default_nettype none

module packed_mac_dsp (
  input  logic               clk,
  input  logic               reset,
  input  logic               acc_en,
  input  logic               acc_clear,
  input  mac_pkg::mac_mode_e mode,
  input  mac_pkg::dsp_p_t    p,
  output mac_pkg::acc_t      acc
);

  import mac_pkg::*;

  // Lanes 0 and 1 share a wide adder across both modes
  logic [LANE8_W-1:0] add0;
  logic [LANE8_W-1:0] add1;
  logic [LANE8_W-1:0] fix1;
  logic [LANE8_W-1:0] old0;
  logic [LANE8_W-1:0] old1;
  logic [LANE8_W-1:0] sum0;
  logic [LANE8_W-1:0] sum1;

  // Lanes 2 and 3 only exist in 4x4 mode
  logic [LANE4_W-1:0] add2;
  logic [LANE4_W-1:0] add3;
  logic [LANE4_W-1:0] fix2;
  logic [LANE4_W-1:0] fix3;
  logic [LANE4_W-1:0] old2;
  logic [LANE4_W-1:0] old3;
  logic [LANE4_W-1:0] sum2;
  logic [LANE4_W-1:0] sum3;

  acc_t acc_next;

  ////////////////////////////////////////
  // Field split and borrow correction
  ////////////////////////////////////////

  // A negative field borrows one from the field above it.
  // Adding its sign bit back to the next field undoes that.
  always_comb begin
    if (mode == MODE_8X8) begin
      add0 = {{(LANE8_W - 16){p[15]}}, p[15:0]};
      add1 = {{(LANE8_W - 16){p[31]}}, p[31:16]};
      fix1 = {{(LANE8_W - 1){1'b0}}, p[15]};
    end else begin
      add0 = {{(LANE8_W - 8){p[7]}}, p[7:0]};
      add1 = {{(LANE8_W - 8){p[15]}}, p[15:8]};
      fix1 = {{(LANE8_W - 1){1'b0}}, p[7]};
    end
    add2 = {{(LANE4_W - 8){p[23]}}, p[23:16]};
    add3 = {{(LANE4_W - 8){p[31]}}, p[31:24]};
    fix2 = {{(LANE4_W - 1){1'b0}}, p[15]};
    fix3 = {{(LANE4_W - 1){1'b0}}, p[23]};
  end

  // Previous lane values, or zero when a job starts
  always_comb begin
    if (acc_clear) begin
      old0 = '0;
      old1 = '0;
      old2 = '0;
      old3 = '0;
    end else begin
      if (mode == MODE_8X8) begin
        old0 = acc[0 +: LANE8_W];
        old1 = acc[LANE8_W +: LANE8_W];
      end else begin
        // Narrow lanes widened for the shared adder
        old0 = {{(LANE8_W - LANE4_W){acc[LANE4_W-1]}}, acc[0 +: LANE4_W]};
        old1 = {{(LANE8_W - LANE4_W){acc[2*LANE4_W-1]}}, acc[LANE4_W +: LANE4_W]};
      end
      old2 = acc[2*LANE4_W +: LANE4_W];
      old3 = acc[3*LANE4_W +: LANE4_W];
    end
  end

  assign sum0 = old0 + add0;
  assign sum1 = old1 + add1 + fix1;
  assign sum2 = old2 + add2 + fix2;
  assign sum3 = old3 + add3 + fix3;

  ////////////////////////////////////////
  // Packed lane register
  ////////////////////////////////////////

  always_comb begin
    acc_next = acc;
    if (mode == MODE_8X8) begin
      acc_next[0 +: LANE8_W]       = sum0;
      acc_next[LANE8_W +: LANE8_W] = sum1;
      // Top bits unused in 8x8 mode, cleared with the job
      if (acc_clear) begin
        acc_next[ACC_W-1:2*LANE8_W] = '0;
      end
    end else begin
      acc_next[0 +: LANE4_W]         = sum0[LANE4_W-1:0];
      acc_next[LANE4_W +: LANE4_W]   = sum1[LANE4_W-1:0];
      acc_next[2*LANE4_W +: LANE4_W] = sum2;
      acc_next[3*LANE4_W +: LANE4_W] = sum3;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (acc_en) begin
      acc <= acc_next;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/packed_mac_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module packed_mac_engine (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_valid,
  input  mac_pkg::mac_beat_s   in_beat,
  input  logic                 out_ready,
  output logic                 in_ready,
  output logic                 out_valid,
  output mac_pkg::mac_result_s out_result
);

  import mac_pkg::*;

  logic      beat_accept;
  logic      acc_en;
  logic      acc_clear;
  mac_mode_e acc_mode;
  dsp_a_t    dsp_a;
  dsp_b_t    dsp_b;
  dsp_p_t    dsp_p;
  acc_t      acc;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  mac_sequencer seq_i (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .in_last     (in_beat.last),
    .in_mode     (in_beat.mode),
    .out_ready   (out_ready),
    .acc         (acc),
    .in_ready    (in_ready),
    .beat_accept (beat_accept),
    .acc_en      (acc_en),
    .acc_clear   (acc_clear),
    .acc_mode    (acc_mode),
    .out_valid   (out_valid),
    .out_result  (out_result)
  );

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  // Packer 1 cycle, multiplier 2, accumulator 1
  operand_packer packer_i (
    .clk         (clk),
    .reset       (reset),
    .beat_accept (beat_accept),
    .beat        (in_beat),
    .dsp_a       (dsp_a),
    .dsp_b       (dsp_b)
  );

  packed_mult_u24_s18 mult_i (
    .clk (clk),
    .a   (dsp_a),
    .b   (dsp_b),
    .p   (dsp_p)
  );

  packed_mac_dsp mac_i (
    .clk       (clk),
    .reset     (reset),
    .acc_en    (acc_en),
    .acc_clear (acc_clear),
    .mode      (acc_mode),
    .p         (dsp_p),
    .acc       (acc)
  );

endmodule

`default_nettype wire

// ==== verilog/packed_mult_u24_s18.sv ====
`timescale 1ns/1ps
`default_nettype none

module packed_mult_u24_s18 (
  input  logic            clk,
  input  mac_pkg::dsp_a_t a,
  input  mac_pkg::dsp_b_t b,
  output mac_pkg::dsp_p_t p
);

  import mac_pkg::*;

  dsp_a_t a_q;
  dsp_b_t b_q;
  dsp_p_t a_ext;
  dsp_p_t b_ext;
  dsp_p_t prod;

  // A zero extended, B sign extended to full product width.
  // The low DSP_P_W bits of the product are then the exact signed result.
  assign a_ext = {{(DSP_P_W - DSP_A_W){1'b0}}, a_q};
  assign b_ext = {{(DSP_P_W - DSP_B_W){b_q[DSP_B_W-1]}}, b_q};
  assign prod  = a_ext * b_ext;

  // Input and output registers, two cycles like the DSP core
  always_ff @(posedge clk) begin
    a_q <= a;
    b_q <= b;
    p   <= prod;
  end

endmodule

`default_nettype wire
